// File: design/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath and register file geometry
`define WORD_SIZE 16
`define REG_COUNT 4
`define REG_SIZE 2

// Instruction field widths, MSB first: opcode, rs, rt, then rd/funct or imm
`define OPCODE_SIZE 4
`define FUNCT_SIZE 6
`define IMM_SIZE 8
`define TARGET_SIZE 12

// Opcodes
`define OP_RTYPE 4'd15
`define OP_ADI 4'd4
`define OP_LHI 4'd6
`define OP_LWD 4'd7
`define OP_SWD 4'd8
`define OP_BNE 4'd0
`define OP_BEQ 4'd1
`define OP_JMP 4'd9

// Funct codes for OP_RTYPE
`define FN_ADD 6'd0
`define FN_SUB 6'd1
`define FN_AND 6'd2
`define FN_ORR 6'd3
`define FN_WWD 6'd28
`define FN_HLT 6'd29

`endif

// File: design/cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

    // Low byte is either rd/funct or the immediate
    typedef struct packed {
        logic [`REG_SIZE-1:0]   rd;
        logic [`FUNCT_SIZE-1:0] funct;
    } rfield_t;

    typedef union packed {
        rfield_t              r;
        logic [`IMM_SIZE-1:0] imm;
    } low_field_t;

    typedef struct packed {
        logic [`OPCODE_SIZE-1:0] opcode;
        logic [`REG_SIZE-1:0]    rs;
        logic [`REG_SIZE-1:0]    rt;
        low_field_t              low;
    } inst_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_pass_b,
        alu_lhi
    } alu_op_t;

    typedef struct packed {
        alu_op_t              alu_op;
        logic                 alu_src_imm;
        logic                 mem_read;
        logic                 mem_write;
        logic                 mem_to_reg;
        logic                 reg_write;
        logic [`REG_SIZE-1:0] wr_reg;
        logic                 branch_eq;
        logic                 branch_ne;
        logic                 jump;
        logic                 wwd;
        logic                 halt;
    } ctrl_t;

    typedef struct packed {
        inst_t                 inst;
        logic [`WORD_SIZE-1:0] pc_next;
    } if_id_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [`WORD_SIZE-1:0] rs_val;
        logic [`WORD_SIZE-1:0] rt_val;
        logic [`WORD_SIZE-1:0] imm;
        logic [`WORD_SIZE-1:0] pc_next;
        logic [`WORD_SIZE-1:0] jump_target;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [`WORD_SIZE-1:0] result;
        logic [`WORD_SIZE-1:0] rs_val;
    } ex_wb_t;

endpackage

// File: design/pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic [15:0]
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     hold,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // Flush turns the slot into a bubble, even while held
    always_ff @(posedge clk) begin
        if (reset_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (!hold) begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves when the stage is not held
    always_ff @(posedge clk) begin
        if (!hold) begin
            out_data <= in_data;
        end
    end

endmodule

// File: design/register_file.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module register_file (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [`REG_SIZE-1:0]  read1,
    input  logic [`REG_SIZE-1:0]  read2,
    input  logic                  wb_en,
    input  logic [`REG_SIZE-1:0]  wb_reg,
    input  logic [`WORD_SIZE-1:0] wb_data,
    output logic [`WORD_SIZE-1:0] read_out1,
    output logic [`WORD_SIZE-1:0] read_out2
);

    logic [`WORD_SIZE-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_reg] <= wb_data;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign read_out1 = (wb_en && wb_reg == read1) ? wb_data : regs[read1];
    assign read_out2 = (wb_en && wb_reg == read2) ? wb_data : regs[read2];

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module fetch_unit
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  stall,
    input  logic                  redirect,
    input  logic [`WORD_SIZE-1:0] target,
    input  logic                  halted,
    output logic                  read_m1,
    output logic [`WORD_SIZE-1:0] address1,
    input  logic [`WORD_SIZE-1:0] data1,
    output if_id_t                if_out
);

    logic [`WORD_SIZE-1:0] pc;
    logic [`WORD_SIZE-1:0] pc_next;

    assign pc_next = pc + `WORD_SIZE'd1;

    //////////////////////////////////////////////////
    // Instruction port
    //////////////////////////////////////////////////

    // Keep reading until the core has retired HLT
    assign read_m1  = ~halted;
    assign address1 = pc;

    assign if_out.inst    = inst_t'(data1);
    assign if_out.pc_next = pc_next;

    //////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////

    // Redirect from EX wins over a decode stall
    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= target;
        end else if (!stall && !halted) begin
            pc <= pc_next;
        end
    end

endmodule

// File: design/decode_unit.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module decode_unit
    import cpu_pkg::*;
(
    input  logic                  if_valid,
    input  if_id_t                if_in,
    input  logic                  ex_valid,
    input  ctrl_t                 ex_ctrl,
    input  logic [`WORD_SIZE-1:0] read_out1,
    input  logic [`WORD_SIZE-1:0] read_out2,
    output logic [`REG_SIZE-1:0]  read1,
    output logic [`REG_SIZE-1:0]  read2,
    output logic                  stall,
    output id_ex_t                id_out
);

    inst_t                 inst;
    logic [`WORD_SIZE-1:0] raw;
    logic [`IMM_SIZE-1:0]  imm;
    ctrl_t                 ctrl;
    logic                  use_rs;
    logic                  use_rt;

    assign inst = if_in.inst;
    assign raw  = if_in.inst;
    assign imm  = inst.low.imm;

    assign read1 = inst.rs;
    assign read2 = inst.rt;

    //////////////////////////////////////////////////
    // Control decode
    //////////////////////////////////////////////////

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = alu_pass_b;
        use_rs      = 1'b0;
        use_rt      = 1'b0;
        case (inst.opcode)
            `OP_RTYPE: begin
                ctrl.wr_reg = inst.low.r.rd;
                case (inst.low.r.funct)
                    `FN_ADD, `FN_SUB, `FN_AND, `FN_ORR: begin
                        ctrl.reg_write = 1'b1;
                        use_rs         = 1'b1;
                        use_rt         = 1'b1;
                        case (inst.low.r.funct)
                            `FN_ADD: ctrl.alu_op = alu_add;
                            `FN_SUB: ctrl.alu_op = alu_sub;
                            `FN_AND: ctrl.alu_op = alu_and;
                            default: ctrl.alu_op = alu_or;
                        endcase
                    end
                    `FN_WWD: begin
                        ctrl.wwd = 1'b1;
                        use_rs   = 1'b1;
                    end
                    `FN_HLT: ctrl.halt = 1'b1;
                    default: ;
                endcase
            end
            `OP_ADI, `OP_LHI, `OP_LWD: begin
                ctrl.alu_op      = (inst.opcode == `OP_LHI) ? alu_lhi : alu_add;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.wr_reg      = inst.rt;
                ctrl.mem_read    = (inst.opcode == `OP_LWD);
                ctrl.mem_to_reg  = (inst.opcode == `OP_LWD);
                use_rs           = (inst.opcode != `OP_LHI);
            end
            `OP_SWD: begin
                ctrl.alu_op      = alu_add;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
                use_rs           = 1'b1;
                use_rt           = 1'b1;
            end
            `OP_BEQ, `OP_BNE: begin
                ctrl.branch_eq = (inst.opcode == `OP_BEQ);
                ctrl.branch_ne = (inst.opcode == `OP_BNE);
                use_rs         = 1'b1;
                use_rt         = 1'b1;
            end
            `OP_JMP: ctrl.jump = 1'b1;
            default: ;
        endcase
    end

    // Producer still in EX has not reached the register file yet
    assign stall = if_valid && ex_valid && ex_ctrl.reg_write &&
                   ((use_rs && ex_ctrl.wr_reg == inst.rs) ||
                    (use_rt && ex_ctrl.wr_reg == inst.rt));

    assign id_out.ctrl        = ctrl;
    assign id_out.rs_val      = read_out1;
    assign id_out.rt_val      = read_out2;
    assign id_out.imm         = {{(`WORD_SIZE-`IMM_SIZE){imm[`IMM_SIZE-1]}}, imm};
    assign id_out.pc_next     = if_in.pc_next;
    assign id_out.jump_target = {if_in.pc_next[`WORD_SIZE-1:`TARGET_SIZE],
                                 raw[`TARGET_SIZE-1:0]};

endmodule

// File: design/execute_unit.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module execute_unit
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  ex_valid,
    input  id_ex_t                ex_in,
    output logic                  redirect,
    output logic [`WORD_SIZE-1:0] target,
    output logic                  read_m2,
    output logic                  write_m2,
    output logic [`WORD_SIZE-1:0] address2,
    output logic [`WORD_SIZE-1:0] data2_out,
    input  logic [`WORD_SIZE-1:0] data2_in,
    input  logic                  wb_valid,
    input  ex_wb_t                wb_in,
    output ex_wb_t                ex_out,
    output logic                  wb_en,
    output logic [`REG_SIZE-1:0]  wb_reg,
    output logic [`WORD_SIZE-1:0] wb_data,
    output logic [`WORD_SIZE-1:0] num_inst,
    output logic [`WORD_SIZE-1:0] output_port,
    output logic                  is_halted
);

    logic                  ex_active;
    logic                  retire;
    logic [`WORD_SIZE-1:0] alu_b;
    logic [`WORD_SIZE-1:0] alu_out;
    logic                  taken;

    // Nothing behind a HLT in WB may touch memory or the PC
    assign ex_active = ex_valid && !is_halted && !(wb_valid && wb_in.ctrl.halt);

    //////////////////////////////////////////////////
    // ALU and branch resolution
    //////////////////////////////////////////////////

    assign alu_b = ex_in.ctrl.alu_src_imm ? ex_in.imm : ex_in.rt_val;

    always_comb begin
        case (ex_in.ctrl.alu_op)
            alu_add: alu_out = ex_in.rs_val + alu_b;
            alu_sub: alu_out = ex_in.rs_val - alu_b;
            alu_and: alu_out = ex_in.rs_val & alu_b;
            alu_or:  alu_out = ex_in.rs_val | alu_b;
            alu_lhi: alu_out = {alu_b[7:0], 8'h00};
            default: alu_out = alu_b;
        endcase
    end

    assign taken = (ex_in.ctrl.branch_eq && ex_in.rs_val == ex_in.rt_val) ||
                   (ex_in.ctrl.branch_ne && ex_in.rs_val != ex_in.rt_val);

    assign redirect = ex_active && (taken || ex_in.ctrl.jump);
    assign target   = ex_in.ctrl.jump ? ex_in.jump_target : ex_in.pc_next + ex_in.imm;

    // Data port, live during the EX cycle
    assign read_m2   = ex_active && ex_in.ctrl.mem_read;
    assign write_m2  = ex_active && ex_in.ctrl.mem_write;
    assign address2  = alu_out;
    assign data2_out = ex_in.rt_val;

    assign ex_out.ctrl   = ex_in.ctrl;
    assign ex_out.result = ex_in.ctrl.mem_to_reg ? data2_in : alu_out;
    assign ex_out.rs_val = ex_in.rs_val;

    //////////////////////////////////////////////////
    // Writeback and retire
    //////////////////////////////////////////////////

    assign retire  = wb_valid && !is_halted;
    assign wb_en   = retire && wb_in.ctrl.reg_write;
    assign wb_reg  = wb_in.ctrl.wr_reg;
    assign wb_data = wb_in.result;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            num_inst    <= '0;
            output_port <= '0;
            is_halted   <= 1'b0;
        end else if (retire) begin
            num_inst <= num_inst + `WORD_SIZE'd1;
            if (wb_in.ctrl.wwd) begin
                output_port <= wb_in.rs_val;
            end
            if (wb_in.ctrl.halt) begin
                is_halted <= 1'b1;
            end
        end
    end

endmodule

// File: design/cpu.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    output logic                  read_m1,
    output logic [`WORD_SIZE-1:0] address1,
    input  logic [`WORD_SIZE-1:0] data1,
    output logic                  read_m2,
    output logic                  write_m2,
    output logic [`WORD_SIZE-1:0] address2,
    input  logic [`WORD_SIZE-1:0] data2_in,
    output logic [`WORD_SIZE-1:0] data2_out,
    output logic [`WORD_SIZE-1:0] num_inst,
    output logic [`WORD_SIZE-1:0] output_port,
    output logic                  is_halted
);

    if_id_t                fetch_out, if_id_q;
    id_ex_t                decode_out, id_ex_q;
    ex_wb_t                exec_out, ex_wb_q;
    logic                  if_id_valid, id_ex_valid, ex_wb_valid;
    logic                  stall, redirect;
    logic [`WORD_SIZE-1:0] target;
    logic [`REG_SIZE-1:0]  read1, read2, wb_reg;
    logic [`WORD_SIZE-1:0] read_out1, read_out2, wb_data;
    logic                  wb_en;

    fetch_unit u_fetch (
        .clk, .reset_n, .stall, .redirect, .target, .halted(is_halted),
        .read_m1, .address1, .data1, .if_out(fetch_out)
    );

    ////////////////////////////////////////////////// IF/ID
    pipe_stage #(.payload_t(if_id_t)) u_if_id (
        .clk, .reset_n, .hold(stall), .flush(redirect),
        .in_valid(read_m1), .in_data(fetch_out),
        .out_valid(if_id_valid), .out_data(if_id_q)
    );

    decode_unit u_decode (
        .if_valid(if_id_valid), .if_in(if_id_q),
        .ex_valid(id_ex_valid), .ex_ctrl(id_ex_q.ctrl),
        .read_out1, .read_out2, .read1, .read2, .stall, .id_out(decode_out)
    );

    register_file u_regs (
        .clk, .reset_n, .read1, .read2, .wb_en, .wb_reg, .wb_data, .read_out1, .read_out2
    );

    ////////////////////////////////////////////////// ID/EX
    pipe_stage #(.payload_t(id_ex_t)) u_id_ex (
        .clk, .reset_n, .hold(1'b0), .flush(stall || redirect),
        .in_valid(if_id_valid), .in_data(decode_out),
        .out_valid(id_ex_valid), .out_data(id_ex_q)
    );

    execute_unit u_execute (
        .clk, .reset_n, .ex_valid(id_ex_valid), .ex_in(id_ex_q),
        .redirect, .target, .read_m2, .write_m2, .address2, .data2_out, .data2_in,
        .wb_valid(ex_wb_valid), .wb_in(ex_wb_q), .ex_out(exec_out),
        .wb_en, .wb_reg, .wb_data, .num_inst, .output_port, .is_halted
    );

    ////////////////////////////////////////////////// EX/WB
    pipe_stage #(.payload_t(ex_wb_t)) u_ex_wb (
        .clk, .reset_n, .hold(1'b0), .flush(is_halted),
        .in_valid(id_ex_valid), .in_data(exec_out),
        .out_valid(ex_wb_valid), .out_data(ex_wb_q)
    );

endmodule

// File: dv/cpu_mem_model.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_mem_model (
    input  logic                  clk,
    input  logic                  read_m1,
    input  logic [`WORD_SIZE-1:0] address1,
    output logic [`WORD_SIZE-1:0] data1,
    input  logic                  read_m2,
    input  logic                  write_m2,
    input  logic [`WORD_SIZE-1:0] address2,
    input  logic [`WORD_SIZE-1:0] data2_out,
    output logic [`WORD_SIZE-1:0] data2_in
);

    logic [`WORD_SIZE-1:0] imem [256];
    logic [`WORD_SIZE-1:0] dmem [256];
    logic [31:0]           lfsr_state = 32'd80145;

    // Both memories answer in the same cycle
    assign data1    = read_m1 ? imem[address1[7:0]] : '0;
    assign data2_in = read_m2 ? dmem[address2[7:0]] : '0;

    // Store commits at the edge closing the EX cycle
    always @(posedge clk) begin
        if (write_m2) begin
            dmem[address2[7:0]] <= data2_out;
        end
    end

    //////////////////////////////////////////////////
    // Loader and random source
    //////////////////////////////////////////////////

    function automatic logic [`WORD_SIZE-1:0] fill_word(input logic [7:0] addr);
        return {addr ^ 8'h5a, ~addr};
    endfunction

    task automatic fill_memories();
        for (int i = 0; i < 256; i++) begin
            imem[i] = fill_word(i[7:0]);
            dmem[i] = fill_word(i[7:0]) ^ 16'h0ff0;
        end
    endtask

    task automatic load_word(input int addr, input logic [`WORD_SIZE-1:0] word);
        imem[addr] = word;
    endtask

    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [`WORD_SIZE-1:0] random_bits(input int count);
        logic [`WORD_SIZE-1:0] value;
        logic                  fb;
        value = '0;
        for (int i = 0; i < count; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[`WORD_SIZE-2:0], fb};
        end
        return value;
    endfunction

endmodule

// File: dv/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_tb
    import cpu_pkg::*;
();

    localparam int DRIVE_DELAY  = 1;
    localparam int HALT_TIMEOUT = 400;

    logic                  clk;
    logic                  reset_n;
    logic                  reset_q = 1'b0;
    logic                  read_m1, read_m2, write_m2, is_halted;
    logic [`WORD_SIZE-1:0] address1, data1, address2, data2_in, data2_out;
    logic [`WORD_SIZE-1:0] num_inst, output_port, prev_port;
    logic                  halted_ok;

    // Program image and the in-order model results
    logic [`WORD_SIZE-1:0] prog [$];
    logic [`WORD_SIZE-1:0] exp_wwd [64];
    logic [`WORD_SIZE-1:0] exp_st_addr [16];
    logic [`WORD_SIZE-1:0] exp_st_data [16];
    int n_wwd, n_store, n_exec;
    int wwd_seen, store_seen;
    int value_errors, other_errors;

    cpu uut (
        .clk, .reset_n, .read_m1, .address1, .data1, .read_m2, .write_m2, .address2,
        .data2_in, .data2_out, .num_inst, .output_port, .is_halted
    );

    cpu_mem_model memory (
        .clk, .read_m1, .address1, .data1, .read_m2, .write_m2, .address2,
        .data2_out, .data2_in
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        reset_q   <= reset_n;
        prev_port <= output_port;
        if (!reset_n && output_port != prev_port) begin
            wwd_seen <= wwd_seen + 1;
        end
        if (!reset_n && write_m2) begin
            store_seen <= store_seen + 1;
        end
    end

    function automatic void count_failure(input string msg);
        value_errors++;
        $display("FAIL %0t: %s", $time, msg);
    endfunction

    //////////////////////////////////////////////////
    // Checkers
    //////////////////////////////////////////////////

    // Reset state holds while reset is high and one cycle after
    reset_state_check: assert property (@(posedge clk)
        reset_q |-> !is_halted && !read_m2 && !write_m2 && num_inst == 0 &&
                    output_port == 0 && address1 == 0)
        else count_failure("outputs not in reset state");

    fetch_enable_check: assert property (@(posedge clk) disable iff (reset_n)
        read_m1 == !is_halted)
        else count_failure("read_m1 does not follow is_halted");

    output_check: assert property (@(posedge clk) disable iff (reset_n)
        !$stable(output_port) |-> wwd_seen < n_wwd && output_port == exp_wwd[wwd_seen])
        else count_failure("output_port change differs from the in-order model");

    store_check: assert property (@(posedge clk) disable iff (reset_n)
        write_m2 |-> store_seen < n_store && address2 == exp_st_addr[store_seen] &&
                     data2_out == exp_st_data[store_seen])
        else count_failure("store address or data differs from the model");

    halt_hold_check: assert property (@(posedge clk) disable iff (reset_n)
        $past(is_halted) |-> is_halted && $stable(output_port) && $stable(num_inst))
        else count_failure("core state moved after halt");

    halt_count_check: assert property (@(posedge clk) disable iff (reset_n)
        $rose(is_halted) |-> num_inst == 16'(n_exec))
        else count_failure("num_inst at halt differs from the model count");

    //////////////////////////////////////////////////
    // Program and reference model
    //////////////////////////////////////////////////

    function automatic logic [`WORD_SIZE-1:0] r_type(input logic [1:0] rs, rt, rd,
                                                     input logic [5:0] funct);
        return {`OP_RTYPE, rs, rt, rd, funct};
    endfunction

    function automatic logic [`WORD_SIZE-1:0] i_type(input logic [3:0] op,
                                                     input logic [1:0] rs, rt,
                                                     input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [7:0] random_imm(input int bits);
        return 8'(memory.random_bits(bits));
    endfunction

    task automatic build_program();
        // Dependent chain where each result feeds the next instruction
        prog.push_back(i_type(`OP_LHI, 2'd0, 2'd1, random_imm(8)));
        prog.push_back(i_type(`OP_ADI, 2'd1, 2'd1, random_imm(8)));
        prog.push_back(i_type(`OP_ADI, 2'd1, 2'd2, random_imm(8)));
        prog.push_back(r_type(2'd1, 2'd2, 2'd3, `FN_ADD));
        prog.push_back(r_type(2'd3, 2'd1, 2'd0, `FN_SUB));
        prog.push_back(r_type(2'd0, 2'd3, 2'd2, `FN_AND));
        prog.push_back(r_type(2'd2, 2'd0, 2'd1, `FN_ORR));
        prog.push_back(r_type(2'd1, 2'd0, 2'd0, `FN_WWD));
        prog.push_back(r_type(2'd3, 2'd0, 2'd0, `FN_WWD));
        // Store and load back through a small base
        prog.push_back(i_type(`OP_LHI, 2'd0, 2'd0, 8'd0));
        prog.push_back(i_type(`OP_ADI, 2'd0, 2'd0, random_imm(6)));
        prog.push_back(i_type(`OP_SWD, 2'd0, 2'd1, 8'd3));
        prog.push_back(i_type(`OP_LWD, 2'd0, 2'd2, 8'd3));
        prog.push_back(r_type(2'd2, 2'd0, 2'd0, `FN_WWD));
        // Taken BEQ skips two WWDs and BNE falls through
        prog.push_back(i_type(`OP_BEQ, 2'd2, 2'd1, 8'd2));
        prog.push_back(r_type(2'd3, 2'd0, 2'd0, `FN_WWD));
        prog.push_back(r_type(2'd0, 2'd0, 2'd0, `FN_WWD));
        prog.push_back(i_type(`OP_BNE, 2'd2, 2'd1, 8'd1));
        prog.push_back(i_type(`OP_ADI, 2'd3, 2'd3, 8'd1));
        prog.push_back(r_type(2'd3, 2'd0, 2'd0, `FN_WWD));
        prog.push_back({`OP_JMP, 12'(prog.size() + 3)});
        prog.push_back(r_type(2'd0, 2'd0, 2'd0, `FN_WWD));
        prog.push_back(r_type(2'd1, 2'd0, 2'd0, `FN_WWD));
        prog.push_back(i_type(`OP_ADI, 2'd0, 2'd0, random_imm(8)));
        prog.push_back(r_type(2'd0, 2'd0, 2'd0, `FN_WWD));
        prog.push_back(r_type(2'd0, 2'd0, 2'd0, `FN_HLT));
    endtask

    // In-order ISA model that records only value changes of output_port
    task automatic run_model();
        logic [`WORD_SIZE-1:0] regs [4];
        logic [`WORD_SIZE-1:0] dmem [256];
        logic [`WORD_SIZE-1:0] pc, pc1, imm, addr, last_out;
        inst_t                 inst;
        logic                  done;
        pc       = '0;
        last_out = '0;
        done     = 1'b0;
        for (int i = 0; i < 4; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = memory.dmem[i];
        end
        for (int step = 0; step < 1000 && !done; step++) begin
            inst = memory.imem[pc[7:0]];
            pc1  = pc + 16'd1;
            imm  = {{8{inst.low.imm[7]}}, inst.low.imm};
            addr = regs[inst.rs] + imm;
            pc   = pc1;
            n_exec++;
            case (inst.opcode)
                `OP_RTYPE: begin
                    case (inst.low.r.funct)
                        `FN_ADD: regs[inst.low.r.rd] = regs[inst.rs] + regs[inst.rt];
                        `FN_SUB: regs[inst.low.r.rd] = regs[inst.rs] - regs[inst.rt];
                        `FN_AND: regs[inst.low.r.rd] = regs[inst.rs] & regs[inst.rt];
                        `FN_ORR: regs[inst.low.r.rd] = regs[inst.rs] | regs[inst.rt];
                        `FN_WWD: begin
                            if (regs[inst.rs] != last_out) begin
                                last_out       = regs[inst.rs];
                                exp_wwd[n_wwd] = last_out;
                                n_wwd++;
                            end
                        end
                        `FN_HLT: done = 1'b1;
                        default: ;
                    endcase
                end
                `OP_ADI: regs[inst.rt] = addr;
                `OP_LHI: regs[inst.rt] = {inst.low.imm, 8'h00};
                `OP_LWD: regs[inst.rt] = dmem[addr[7:0]];
                `OP_SWD: begin
                    dmem[addr[7:0]]      = regs[inst.rt];
                    exp_st_addr[n_store] = addr;
                    exp_st_data[n_store] = regs[inst.rt];
                    n_store++;
                end
                `OP_BEQ: pc = (regs[inst.rs] == regs[inst.rt]) ? pc1 + imm : pc1;
                `OP_BNE: pc = (regs[inst.rs] != regs[inst.rt]) ? pc1 + imm : pc1;
                `OP_JMP: pc = {pc1[15:12], inst[11:0]};
                default: ;
            endcase
        end
    endtask

    initial begin
        reset_n = 1'b1;
        memory.fill_memories();
        build_program();
        foreach (prog[i]) begin
            memory.load_word(i, prog[i]);
        end
        run_model();
        repeat (5) @(posedge clk);
        #DRIVE_DELAY reset_n = 1'b0;

        halted_ok = 1'b0;
        for (int cycle = 0; cycle < HALT_TIMEOUT && !halted_ok; cycle++) begin
            @(negedge clk);
            halted_ok = is_halted;
        end

        if (!halted_ok) begin
            other_errors++;
            $display("Timeout: the core did not halt within %0d cycles", HALT_TIMEOUT);
        end else begin
            // Quiet period so the halt checkers see a few cycles
            repeat (8) @(negedge clk);
            assert (wwd_seen == n_wwd)
                else count_failure("output_port changed fewer times than the model");
            assert (store_seen == n_store)
                else count_failure("store count differs from the model");
            assert (num_inst == 16'(n_exec))
                else count_failure("final num_inst differs from the model count");
        end

        $display("Error counts: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+design
design/cpu_pkg.sv
design/pipe_stage.sv
design/register_file.sv
design/fetch_unit.sv
design/decode_unit.sv
design/execute_unit.sv
design/cpu.sv
dv/cpu_mem_model.sv
dv/cpu_tb.sv
